//--- source/rib_map_pkg.sv
/*
 rib address map
 bus widths, the slave select field at the top of the address
 and the numbers of the slaves hanging off the bus
*/
package rib_map_pkg;

    localparam int ADDR_W = 32;                 // bus address width
    localparam int DATA_W = 32;                 // bus data width

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // top nibble of the address picks the slave, so 16 slaves at most
    localparam int SEL_W   = 4;
    localparam int SEL_LSB = ADDR_W - SEL_W;    // lowest bit of the select field

    typedef logic [SEL_W-1:0] sel_t;

    localparam int NUM_SLAVES = 4;
    localparam int SLV_IDX_W  = $clog2(NUM_SLAVES); // index into the slave ports

    localparam sel_t SLV_ROM   = sel_t'(0);     // boot rom
    localparam sel_t SLV_RAM   = sel_t'(1);     // data ram
    localparam sel_t SLV_TIMER = sel_t'(2);
    localparam sel_t SLV_UART  = sel_t'(3);

endpackage

//--- source/rib_arb_pkg.sv
/*
 rib arbitration definitions
 master count, bus owner encoding and the read data
 an idle master sees
*/
package rib_arb_pkg;

    localparam int NUM_MASTERS = 3;

    // values double as master index
    typedef enum logic [1:0] {
        GRANT_M0 = 2'd0,                        // data port
        GRANT_M1 = 2'd1,                        // instruction fetch
        GRANT_M2 = 2'd2                         // debug port
    } grant_t;

    localparam grant_t GRANT_RESET = GRANT_M1;  // fetch owns an idle bus

    localparam rib_map_pkg::data_t IDLE_RDATA = '0;
    localparam rib_map_pkg::data_t INST_NOP   = 32'h0000_0013; // addi x0, x0, 0

endpackage

//--- source/rib_if.sv
/*
 rib bus port
 one master or slave connection: address, write data, read data,
 ack, request and write flag with plain level handshake
*/
`timescale 1ns/1ps

interface rib_if;

    rib_map_pkg::addr_t addr;
    rib_map_pkg::data_t wdata;
    rib_map_pkg::data_t rdata;
    logic               ack;                    // access done while req high
    logic               req;                    // held until ack
    logic               we;                     // only valid with req

    modport master (
        output addr,
        output wdata,
        output req,
        output we,
        input  rdata,
        input  ack
    );

    modport slave (
        input  addr,
        input  wdata,
        input  req,
        input  we,
        output rdata,
        output ack
    );

endinterface

//--- source/rib_arbiter.sv
/*
 rib arbiter
 fixed priority grant for the three bus masters:
 data port first, then debug, then instruction fetch.
 the owner is registered, and hold_o stalls the pipeline
 while data or debug port asks for the bus
*/
`timescale 1ns/1ps

module rib_arbiter (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [rib_arb_pkg::NUM_MASTERS-1:0] req_i,
    output rib_arb_pkg::grant_t                 grant_o,
    output logic                                hold_o
);

    import rib_arb_pkg::*;

    grant_t next_grant;
    logic   stall_req;

    // data or debug port wants the bus
    assign stall_req = req_i[GRANT_M0] | req_i[GRANT_M2];

    always_comb begin
        if (req_i[GRANT_M0]) begin
            next_grant = GRANT_M0;
        end else if (req_i[GRANT_M2]) begin
            next_grant = GRANT_M2;
        end else begin
            next_grant = GRANT_M1;              // fetch by default
        end
    end

    assign hold_o = stall_req & ~reset_i;       // no stall during reset

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_o <= GRANT_RESET;
        end else begin
            grant_o <= next_grant;
        end
    end

    // owner is always a real master
    a_grant_legal : assert property (
        @(posedge clk) disable iff (reset_i)
        grant_o inside {GRANT_M0, GRANT_M1, GRANT_M2}
    );

    // taking the bus from fetch stalls the pipeline, and the owner
    // follows one cycle later
    a_hold_on_steal : assert property (
        @(posedge clk) disable iff (reset_i)
        (next_grant != GRANT_M1) |-> hold_o ##1 (grant_o == $past(next_grant))
    );

endmodule

//--- source/rib_router.sv
/*
 rib router
 combinational path between the granted master and the slaves.
 the top address nibble picks the slave, which sees the address
 with that nibble cleared; ack and read data go back to the
 owner only, other masters get their idle values
*/
`timescale 1ns/1ps

module rib_router (
    input rib_arb_pkg::grant_t grant_i,
    rib_if.slave               mst [rib_arb_pkg::NUM_MASTERS],
    rib_if.master              slv [rib_map_pkg::NUM_SLAVES]
);

    import rib_map_pkg::*;
    import rib_arb_pkg::*;

    addr_t                  m_addr  [NUM_MASTERS];
    data_t                  m_wdata [NUM_MASTERS];
    data_t                  m_rdata [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_req;
    logic [NUM_MASTERS-1:0] m_we;
    logic [NUM_MASTERS-1:0] m_ack;

    addr_t                  s_addr  [NUM_SLAVES];
    data_t                  s_wdata [NUM_SLAVES];
    data_t                  s_rdata [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  s_req;
    logic [NUM_SLAVES-1:0]  s_we;
    logic [NUM_SLAVES-1:0]  s_ack;

    addr_t                  own_addr;
    sel_t                   own_sel;
    logic                   own_hit;            // select field maps to a slave
    logic [SLV_IDX_W-1:0]   own_slv;

    function automatic logic sel_mapped(input sel_t sel);
        case (sel)
            SLV_ROM, SLV_RAM, SLV_TIMER, SLV_UART: sel_mapped = 1'b1;
            default:                               sel_mapped = 1'b0;
        endcase
    endfunction

    // unpack the interface arrays
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
        assign m_addr[m]    = mst[m].addr;
        assign m_wdata[m]   = mst[m].wdata;
        assign m_req[m]     = mst[m].req;
        assign m_we[m]      = mst[m].we;
        assign mst[m].rdata = m_rdata[m];
        assign mst[m].ack   = m_ack[m];
    end

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
        assign slv[s].addr  = s_addr[s];
        assign slv[s].wdata = s_wdata[s];
        assign slv[s].req   = s_req[s];
        assign slv[s].we    = s_we[s];
        assign s_rdata[s]   = slv[s].rdata;
        assign s_ack[s]     = slv[s].ack;
    end

    assign own_addr = m_addr[grant_i];
    assign own_sel  = own_addr[SEL_LSB +: SEL_W];
    assign own_hit  = sel_mapped(own_sel);
    assign own_slv  = own_sel[SLV_IDX_W-1:0];

    // forward path, owner to the selected slave
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_req[s]   = 1'b0;
            s_we[s]    = 1'b0;
            s_addr[s]  = '0;
            s_wdata[s] = '0;
        end
        if (own_hit) begin
            s_req[own_slv]   = m_req[grant_i];
            s_we[own_slv]    = m_we[grant_i];
            s_addr[own_slv]  = {{SEL_W{1'b0}}, own_addr[SEL_LSB-1:0]};
            s_wdata[own_slv] = m_wdata[grant_i];
        end
    end

    // return path, selected slave back to the owner
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_ack[m]   = 1'b0;
            m_rdata[m] = (m == int'(GRANT_M1)) ? INST_NOP : IDLE_RDATA; // fetch idles on nop
        end
        if (own_hit) begin
            m_ack[grant_i]   = s_ack[own_slv];
            m_rdata[grant_i] = s_rdata[own_slv];
        end
    end

    always_comb begin
        a_one_slave : assert final ($onehot0(s_req));
    end

endmodule

//--- source/rib_top.sv
/*
 rib bus top level
 three masters (data, fetch, debug) share one bus to four
 slaves (rom, ram, timer, uart) through the arbiter and router
*/
`timescale 1ns/1ps

module rib_top (
    input  logic                                clk,
    input  logic                                reset_i,

    // masters, indexed by master number
    input  rib_map_pkg::addr_t                  m_addr_i  [rib_arb_pkg::NUM_MASTERS],
    input  rib_map_pkg::data_t                  m_wdata_i [rib_arb_pkg::NUM_MASTERS],
    output rib_map_pkg::data_t                  m_rdata_o [rib_arb_pkg::NUM_MASTERS],
    output logic [rib_arb_pkg::NUM_MASTERS-1:0] m_ack_o,
    input  logic [rib_arb_pkg::NUM_MASTERS-1:0] m_req_i,
    input  logic [rib_arb_pkg::NUM_MASTERS-1:0] m_we_i,

    // slaves, indexed by slave number
    output rib_map_pkg::addr_t                  s_addr_o  [rib_map_pkg::NUM_SLAVES],
    output rib_map_pkg::data_t                  s_wdata_o [rib_map_pkg::NUM_SLAVES],
    input  rib_map_pkg::data_t                  s_rdata_i [rib_map_pkg::NUM_SLAVES],
    input  logic [rib_map_pkg::NUM_SLAVES-1:0]  s_ack_i,
    output logic [rib_map_pkg::NUM_SLAVES-1:0]  s_req_o,
    output logic [rib_map_pkg::NUM_SLAVES-1:0]  s_we_o,

    output logic                                hold_o      // pipeline stall
);

    import rib_map_pkg::*;
    import rib_arb_pkg::*;

    grant_t grant;

    rib_if mst_if [NUM_MASTERS] ();
    rib_if slv_if [NUM_SLAVES] ();

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_mst
        assign mst_if[m].addr  = m_addr_i[m];
        assign mst_if[m].wdata = m_wdata_i[m];
        assign mst_if[m].req   = m_req_i[m];
        assign mst_if[m].we    = m_we_i[m];
        assign m_rdata_o[m]    = mst_if[m].rdata;
        assign m_ack_o[m]      = mst_if[m].ack;
    end

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slv
        assign s_addr_o[s]     = slv_if[s].addr;
        assign s_wdata_o[s]    = slv_if[s].wdata;
        assign s_req_o[s]      = slv_if[s].req;
        assign s_we_o[s]       = slv_if[s].we;
        assign slv_if[s].rdata = s_rdata_i[s];
        assign slv_if[s].ack   = s_ack_i[s];
    end

    rib_arbiter u_arbiter (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (m_req_i),
        .grant_o (grant),
        .hold_o  (hold_o)
    );

    rib_router u_router (
        .grant_i (grant),
        .mst     (mst_if),
        .slv     (slv_if)
    );

endmodule

//--- dv/rib_checker.sv
/*
 rib bus checker
 own owner register and routing model, compares every dut output
 on the falling edge and mirrors acknowledged writes
*/
`timescale 1ns/1ps

module rib_checker (
    input logic                                clk,
    input logic                                reset_i,
    input rib_map_pkg::addr_t                  m_addr_i  [rib_arb_pkg::NUM_MASTERS],
    input rib_map_pkg::data_t                  m_wdata_i [rib_arb_pkg::NUM_MASTERS],
    input rib_map_pkg::data_t                  m_rdata_o [rib_arb_pkg::NUM_MASTERS],
    input logic [rib_arb_pkg::NUM_MASTERS-1:0] m_ack_o,
    input logic [rib_arb_pkg::NUM_MASTERS-1:0] m_req_i,
    input logic [rib_arb_pkg::NUM_MASTERS-1:0] m_we_i,
    input rib_map_pkg::addr_t                  s_addr_o  [rib_map_pkg::NUM_SLAVES],
    input rib_map_pkg::data_t                  s_wdata_o [rib_map_pkg::NUM_SLAVES],
    input rib_map_pkg::data_t                  s_rdata_i [rib_map_pkg::NUM_SLAVES],
    input logic [rib_map_pkg::NUM_SLAVES-1:0]  s_ack_i,
    input logic [rib_map_pkg::NUM_SLAVES-1:0]  s_req_o,
    input logic [rib_map_pkg::NUM_SLAVES-1:0]  s_we_o,
    input logic                                hold_o
);

    import rib_map_pkg::*;
    import rib_arb_pkg::*;

    localparam int MEM_WORDS = 16;

    int    err_cnt   = 0;
    int    check_cnt = 0;
    int    owner;                               // expected bus owner
    data_t mirror    [NUM_SLAVES][MEM_WORDS];
    logic  mirror_ok [NUM_SLAVES][MEM_WORDS];   // offset written at least once

    task automatic compare(input string name, input data_t exp, input data_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    initial begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mirror_ok[s][w] = 1'b0;
            end
        end
    end

    // data port beats debug, fetch gets what is left
    always @(posedge clk) begin
        if (reset_i) begin
            owner <= 1;
        end else if (m_req_i[0]) begin
            owner <= 0;
        end else if (m_req_i[2]) begin
            owner <= 2;
        end else begin
            owner <= 1;
        end
    end

    always @(negedge clk) begin
        sel_t  sel;
        logic  hit;
        logic  pick;
        int    word;
        data_t idle;
        compare("hold", data_t'(!reset_i && (m_req_i[0] || m_req_i[2])), data_t'(hold_o));
        if (!reset_i) begin
            sel  = m_addr_i[owner][31:28];
            hit  = sel < NUM_SLAVES;
            word = int'(m_addr_i[owner][5:2]);
            for (int s = 0; s < NUM_SLAVES; s++) begin
                pick = hit && (sel == s);
                compare($sformatf("slave%0d_req", s), data_t'(pick & m_req_i[owner]),
                        data_t'(s_req_o[s]));
                compare($sformatf("slave%0d_we", s), data_t'(pick & m_we_i[owner]),
                        data_t'(s_we_o[s]));
                compare($sformatf("slave%0d_addr", s),
                        pick ? {4'h0, m_addr_i[owner][27:0]} : '0, s_addr_o[s]);
                compare($sformatf("slave%0d_wdata", s), pick ? m_wdata_i[owner] : '0,
                        s_wdata_o[s]);
            end
            for (int m = 0; m < NUM_MASTERS; m++) begin
                pick = hit && (m == owner);
                idle = (m == 1) ? 32'h0000_0013 : '0;
                compare($sformatf("master%0d_ack", m), data_t'(pick & s_ack_i[sel[1:0]]),
                        data_t'(m_ack_o[m]));
                compare($sformatf("master%0d_rdata", m), pick ? s_rdata_i[sel[1:0]] : idle,
                        m_rdata_o[m]);
            end
            if (hit && m_req_i[owner] && s_ack_i[sel[1:0]]) begin
                if (m_we_i[owner]) begin
                    mirror[sel][word]    = m_wdata_i[owner];
                    mirror_ok[sel][word] = 1'b1;
                end else if (mirror_ok[sel][word]) begin
                    compare("read_back", mirror[sel][word], m_rdata_o[owner]);
                end
            end
        end
    end

endmodule

//--- dv/rib_tb.sv
/*
 rib bus testbench
 seeded random traffic from the three masters, small word memories
 as slave models and a watchdog. comparing is done by rib_checker
*/
`timescale 1ns/1ps

module rib_tb;

    import rib_map_pkg::*;
    import rib_arb_pkg::*;

    localparam int SEED         = 79;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_CYCLES     = 2000;
    localparam int MEM_WORDS    = 16;           // words per slave model
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_CYCLES + 50) * CLK_PERIOD;
    localparam int REQ_PCT [NUM_MASTERS] = '{30, 70, 20}; // request odds per master

    logic                   clk;
    logic                   reset_i;
    addr_t                  m_addr  [NUM_MASTERS];
    data_t                  m_wdata [NUM_MASTERS];
    data_t                  m_rdata [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_ack;
    logic [NUM_MASTERS-1:0] m_req;
    logic [NUM_MASTERS-1:0] m_we;
    addr_t                  s_addr  [NUM_SLAVES];
    data_t                  s_wdata [NUM_SLAVES];
    data_t                  s_rdata [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  s_ack;
    logic [NUM_SLAVES-1:0]  s_req;
    logic [NUM_SLAVES-1:0]  s_we;
    logic                   hold;

    data_t       mem      [NUM_SLAVES][MEM_WORDS];
    logic [1:0]  wait_cnt [NUM_SLAVES];         // cycles since req rose
    logic [1:0]  wait_len [NUM_SLAVES];         // ack delay of current access

    rib_top dut (
        .clk       (clk),
        .reset_i   (reset_i),
        .m_addr_i  (m_addr),
        .m_wdata_i (m_wdata),
        .m_rdata_o (m_rdata),
        .m_ack_o   (m_ack),
        .m_req_i   (m_req),
        .m_we_i    (m_we),
        .s_addr_o  (s_addr),
        .s_wdata_o (s_wdata),
        .s_rdata_i (s_rdata),
        .s_ack_i   (s_ack),
        .s_req_o   (s_req),
        .s_we_o    (s_we),
        .hold_o    (hold)
    );

    rib_checker chk (
        .clk       (clk),
        .reset_i   (reset_i),
        .m_addr_i  (m_addr),
        .m_wdata_i (m_wdata),
        .m_rdata_o (m_rdata),
        .m_ack_o   (m_ack),
        .m_req_i   (m_req),
        .m_we_i    (m_we),
        .s_addr_o  (s_addr),
        .s_wdata_o (s_wdata),
        .s_rdata_i (s_rdata),
        .s_ack_i   (s_ack),
        .s_req_o   (s_req),
        .s_we_o    (s_we),
        .hold_o    (hold)
    );

    // mostly mapped slaves, now and then an unmapped nibble
    function automatic addr_t rand_addr();
        sel_t       sel;
        logic [3:0] word;
        if ($urandom_range(7, 0) < 6) begin
            sel = sel_t'($urandom_range(NUM_SLAVES - 1, 0));
        end else begin
            sel = sel_t'($urandom_range(15, NUM_SLAVES));
        end
        word = 4'($urandom_range(MEM_WORDS - 1, 0));
        rand_addr = {sel, 22'h0, word, 2'b00};
    endfunction

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (reset_i) begin
                m_req[m]   <= 1'b0;
                m_we[m]    <= 1'b0;
                m_addr[m]  <= '0;
                m_wdata[m] <= '0;
            end else begin
                m_req[m]   <= ($urandom_range(99, 0) < REQ_PCT[m]);
                m_we[m]    <= $urandom_range(1, 0) == 1;
                m_addr[m]  <= rand_addr();
                m_wdata[m] <= $urandom;
            end
        end
    end

    // slave models: ack after 0..2 cycles, write lands on the acked cycle
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        assign s_ack[s]   = s_req[s] & (wait_cnt[s] >= wait_len[s]);
        assign s_rdata[s] = mem[s][s_addr[s][5:2]];
    end

    always @(posedge clk) begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            if (reset_i) begin
                wait_cnt[s] <= '0;
                wait_len[s] <= '0;
            end else if (s_req[s] && s_ack[s]) begin
                if (s_we[s]) begin
                    mem[s][s_addr[s][5:2]] <= s_wdata[s];
                end
                wait_cnt[s] <= '0;
                wait_len[s] <= 2'($urandom_range(2, 0));
            end else if (s_req[s]) begin
                wait_cnt[s] <= wait_cnt[s] + 2'd1;
            end else begin
                wait_cnt[s] <= '0;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        clk      = 1'b0;
        reset_i  = 1'b1;
        m_req    = '0;
        m_we     = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            m_addr[m]  = '0;
            m_wdata[m] = '0;
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            wait_cnt[s] = '0;
            wait_len[s] = '0;
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[s][w] = 32'h5A00_0000 ^ (s << 16) ^ (w * 32'h0001_0101);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        repeat (N_CYCLES) @(posedge clk);
        @(posedge clk);                         // last checker sample is done
        $display("checks %0d, errors %0d", chk.check_cnt, chk.err_cnt);
        if (chk.err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish in time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- vlog.f
source/rib_map_pkg.sv
source/rib_arb_pkg.sv
source/rib_if.sv
source/rib_arbiter.sv
source/rib_router.sv
source/rib_top.sv
dv/rib_checker.sv
dv/rib_tb.sv

//--- Makefile
# Verilator build and run for the rib bus testbench

VERILATOR   ?= verilator
TOP         ?= rib_tb
FILELIST    ?= vlog.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_MSG    ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
